//--- src/muldiv_data_pkg.sv
////////////////////////////////////////////////////////////
// Datapath widths, step counts and vector types of the
// multiply/divide unit. Every RTL module imports it.
////////////////////////////////////////////////////////////
`default_nettype none

package muldiv_data_pkg;

  // Operand and result word
  localparam int XLEN = 32;
  // Sign-extended operand, also the width of each step register
  localparam int EXT_W = XLEN + 1;
  // Shared adder width with two Booth guard bits
  localparam int SUM_W = XLEN + 3;
  // Divider works on the low 34 bits of the adder
  localparam int DIV_W = XLEN + 2;

  // Execute steps per operation class
  localparam int MUL_STEPS = 16;
  localparam int DIV_STEPS = 32;
  // Counter must reach DIV_STEPS
  localparam int CNT_W = 6;

  typedef logic [XLEN-1:0]  xlen_t;
  typedef logic [EXT_W-1:0] ext_t;
  typedef logic [SUM_W-1:0] sum_t;
  typedef logic [CNT_W-1:0] cnt_t;

endpackage

`default_nettype wire

//--- src/muldiv_ctrl_pkg.sv
////////////////////////////////////////////////////////////
// Operation codes and FSM states of the multiply/divide unit
////////////////////////////////////////////////////////////
`default_nettype none

package muldiv_ctrl_pkg;

  // Top bit set marks a divide-class operation
  typedef enum logic [2:0] {
    OP_MUL    = 3'd0,
    OP_MULH   = 3'd1,
    OP_MULHSU = 3'd2,
    OP_MULHU  = 3'd3,
    OP_DIV    = 3'd4,
    OP_DIVU   = 3'd5,
    OP_REM    = 3'd6,
    OP_REMU   = 3'd7
  } muldiv_op_e;

  // Idle also covers the first step of a new request
  typedef enum logic [2:0] {
    ST_IDLE      = 3'd0,
    ST_EXEC      = 3'd1,
    ST_REMD_CHCK = 3'd2,
    ST_QUOT_CORR = 3'd3,
    ST_REMD_CORR = 3'd4
  } muldiv_state_e;

endpackage

`default_nettype wire

//--- src/muldiv_fsm.sv
////////////////////////////////////////////////////////////
// Control FSM of the multiply/divide unit. Runs the step
// counter, the valid/ready handshake and the step-register
// enables for both the Booth multiplier and the divider.
////////////////////////////////////////////////////////////
`default_nettype none

module muldiv_fsm (
  input  wire logic                          clk,
  input  wire logic                          i_arst_n,
  input  wire logic                          i_valid,
  input  wire muldiv_ctrl_pkg::muldiv_op_e   i_op,
  input  wire logic                          i_special,
  input  wire logic                          i_need_corr,
  input  wire logic                          i_o_ready,
  output logic                               o_i_ready,
  output logic                               o_valid,
  output muldiv_ctrl_pkg::muldiv_state_e     o_state,
  output muldiv_data_pkg::cnt_t              o_cnt,
  output logic                               o_buf0_ena,
  output logic                               o_buf1_ena
);
  import muldiv_data_pkg::*;
  import muldiv_ctrl_pkg::*;

  muldiv_state_e state_q;
  muldiv_state_e state_d;
  cnt_t          cnt_q;
  logic          is_div;
  logic          exec_last;
  logic          wbck;
  logic          o_hsk;
  logic          exec_step;
  logic          exec_exit;

  assign is_div    = i_op[2];
  // Last execute step depends on the operation class
  assign exec_last = is_div ? (cnt_q == cnt_t'(DIV_STEPS)) : (cnt_q == cnt_t'(MUL_STEPS));

  // Result ready: special case at once, multiply after the last step,
  // divide after the check or after the remainder correction
  assign wbck = ((state_q == ST_IDLE) & i_special)
              | ((state_q == ST_EXEC) & exec_last & ~is_div)
              | ((state_q == ST_REMD_CHCK) & ~i_need_corr)
              | (state_q == ST_REMD_CORR);

  assign o_valid   = wbck & i_valid;
  assign o_i_ready = o_valid & i_o_ready;
  assign o_hsk     = o_i_ready;

  // First step happens in idle, the rest in exec
  assign exec_step = ((state_q == ST_IDLE) & i_valid & ~i_special)
                   | ((state_q == ST_EXEC) & ~exec_last);
  assign exec_exit = (state_q == ST_EXEC) & exec_last & (is_div | o_hsk);

  assign o_buf0_ena = exec_step | exec_exit | ((state_q == ST_REMD_CORR) & o_hsk);
  assign o_buf1_ena = exec_step | exec_exit | (state_q == ST_QUOT_CORR);

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE:      if (i_valid & ~i_special) state_d = ST_EXEC;
      ST_EXEC: begin
        if (exec_last & is_div) begin
          state_d = ST_REMD_CHCK;
        end else if (exec_last & o_hsk) begin
          state_d = ST_IDLE;
        end
      end
      ST_REMD_CHCK: begin
        if (i_need_corr) begin
          state_d = ST_QUOT_CORR;
        end else if (o_hsk) begin
          state_d = ST_IDLE;
        end
      end
      ST_QUOT_CORR: state_d = ST_REMD_CORR;
      ST_REMD_CORR: if (o_hsk) state_d = ST_IDLE;
      default:      state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      state_q <= ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Counter starts at 1 because the idle cycle is step 0
  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      cnt_q <= '0;
    end else if (exec_step) begin
      cnt_q <= (state_q == ST_IDLE) ? cnt_t'(1) : cnt_q + cnt_t'(1);
    end
  end

  assign o_state = state_q;
  assign o_cnt   = cnt_q;

  ////////////////////////////////////////////////////////////
  // Checks

  // A stalled result keeps its request alive
  a_valid_held: assert property (@(posedge clk) disable iff (!i_arst_n)
    (o_valid && !i_o_ready) |=> (i_valid && o_valid))
    else $error("o_valid dropped or i_valid released under back-pressure");

  a_cnt_range: assert property (@(posedge clk) disable iff (!i_arst_n)
    cnt_q <= cnt_t'(DIV_STEPS))
    else $error("step counter beyond DIV_STEPS");

  // Operands are read on every step, so the request must not move while busy
  a_req_held: assert property (@(posedge clk) disable iff (!i_arst_n)
    (state_q != ST_IDLE) |-> (i_valid && $stable(i_op)))
    else $error("request dropped or changed while the unit is busy");

endmodule

`default_nettype wire

//--- src/muldiv_booth.sv
////////////////////////////////////////////////////////////
// Radix-4 Booth multiplier step. Forms the adder operands,
// the next product halves and the multiply result.
////////////////////////////////////////////////////////////
`default_nettype none

module muldiv_booth (
  input  wire logic                          clk,
  input  wire logic                          i_arst_n,
  input  wire muldiv_data_pkg::xlen_t        i_rs1,
  input  wire muldiv_data_pkg::xlen_t        i_rs2,
  input  wire muldiv_ctrl_pkg::muldiv_op_e   i_op,
  input  wire muldiv_ctrl_pkg::muldiv_state_e i_state,
  input  wire muldiv_data_pkg::cnt_t         i_cnt,
  input  wire muldiv_data_pkg::ext_t         i_buf0,
  input  wire muldiv_data_pkg::ext_t         i_buf1,
  input  wire muldiv_data_pkg::sum_t         i_sum,
  input  wire logic                          i_buf1_ena,
  output muldiv_data_pkg::sum_t              o_op1,
  output muldiv_data_pkg::sum_t              o_op2,
  output logic                               o_sub,
  output muldiv_data_pkg::ext_t              o_buf0_nxt,
  output muldiv_data_pkg::ext_t              o_buf1_nxt,
  output muldiv_data_pkg::xlen_t             o_result
);
  import muldiv_data_pkg::*;
  import muldiv_ctrl_pkg::*;

  logic       rs1_sign;
  logic       rs2_sign;
  logic       first;
  logic       last;
  logic       sft1_q;
  logic [2:0] code;
  logic       sel_one;
  logic       sel_two;

  // MULHU treats both operands as unsigned, MULHSU only rs2
  assign rs1_sign = (i_op == OP_MULHU) ? 1'b0 : i_rs1[XLEN-1];
  assign rs2_sign = ((i_op == OP_MULHSU) | (i_op == OP_MULHU)) ? 1'b0 : i_rs2[XLEN-1];

  assign first = (i_state == ST_IDLE);
  assign last  = (i_cnt == cnt_t'(MUL_STEPS));

  // Booth window of three multiplier bits
  assign code = first ? {i_rs1[1:0], 1'b0}
              : last  ? {rs1_sign, i_buf1[0], sft1_q}
              :         {i_buf1[1:0], sft1_q};

  assign sel_two  = (code == 3'b011) | (code == 3'b100);
  assign sel_one  = (code == 3'b001) | (code == 3'b010) | (code == 3'b101) | (code == 3'b110);
  // Upper half of the table subtracts
  assign o_sub    = code[2];

  assign o_op1 = first ? '0 : {i_buf0[XLEN], i_buf0[XLEN], i_buf0};
  assign o_op2 = sel_one ? {{3{rs2_sign}}, i_rs2}
               : sel_two ? {{2{rs2_sign}}, i_rs2, 1'b0}
               :           '0;

  // Product shifts right by two per step
  assign o_buf0_nxt = i_sum[SUM_W-1:2];
  assign o_buf1_nxt = {i_sum[1:0], first ? {rs1_sign, i_rs1[XLEN-1:2]} : i_buf1[XLEN:2]};

  // Bit shifted out of the low half, next step's Booth LSB
  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      sft1_q <= 1'b0;
    end else if (i_buf1_ena) begin
      sft1_q <= first ? i_rs1[1] : i_buf1[1];
    end
  end

  // High word comes straight from the adder on the last step
  assign o_result = (i_op == OP_MUL) ? i_buf1[XLEN:1] : i_sum[XLEN-1:0];

  // Last window holds only the multiplier sign and rs1[31], so it never picks two
  a_booth_last: assert property (@(posedge clk) disable iff (!i_arst_n)
    (!i_op[2] && (i_state == ST_EXEC) && last)
      |-> ((i_buf1[0] == rs1_sign) && (sft1_q == i_rs1[XLEN-1])))
    else $error("Booth window misaligned on the last multiply step");

endmodule

`default_nettype wire

//--- src/muldiv_nrdiv.sv
////////////////////////////////////////////////////////////
// Non-restoring divider step with remainder check and the
// quotient/remainder correction. Also answers divide by
// zero and signed overflow without running the steps.
////////////////////////////////////////////////////////////
`default_nettype none

module muldiv_nrdiv (
  input  wire logic                          clk,
  input  wire logic                          i_arst_n,
  input  wire muldiv_data_pkg::xlen_t        i_rs1,
  input  wire muldiv_data_pkg::xlen_t        i_rs2,
  input  wire muldiv_ctrl_pkg::muldiv_op_e   i_op,
  input  wire muldiv_ctrl_pkg::muldiv_state_e i_state,
  input  wire muldiv_data_pkg::cnt_t         i_cnt,
  input  wire muldiv_data_pkg::ext_t         i_buf0,
  input  wire muldiv_data_pkg::ext_t         i_buf1,
  input  wire muldiv_data_pkg::sum_t         i_sum,
  input  wire logic                          i_buf0_ena,
  output muldiv_data_pkg::sum_t              o_op1,
  output muldiv_data_pkg::sum_t              o_op2,
  output logic                               o_sub,
  output muldiv_data_pkg::ext_t              o_buf0_nxt,
  output muldiv_data_pkg::ext_t              o_buf1_nxt,
  output logic                               o_need_corr,
  output logic                               o_special,
  output muldiv_data_pkg::xlen_t             o_result
);
  import muldiv_data_pkg::*;
  import muldiv_ctrl_pkg::*;

  logic             is_uns;
  logic             quot_sel;
  logic             s1;
  logic             s2;
  logic             q0;
  logic             cur_q;
  logic             sft1_q;
  logic             quot_dec;
  logic             div_by_0;
  logic             div_ovf;
  logic [DIV_W-1:0] divisor;
  logic [DIV_W-1:0] op1;
  logic [DIV_W-1:0] op2;
  ext_t             q_src;
  xlen_t            special_res;
  xlen_t            remd;

  assign is_uns   = (i_op == OP_DIVU) | (i_op == OP_REMU);
  assign quot_sel = (i_op == OP_DIV) | (i_op == OP_DIVU);
  assign s1       = ~is_uns & i_rs1[XLEN-1];
  assign s2       = ~is_uns & i_rs2[XLEN-1];
  assign divisor  = {s2, s2, i_rs2};

  // First quotient digit is -1 when dividend and divisor signs differ
  assign q0    = ~(s1 ^ s2);
  assign cur_q = ~(i_sum[DIV_W-1] ^ s2);
  // Quotient bits shift in from the bottom, dividend bits out of the top
  assign q_src = (i_state == ST_IDLE) ? {i_rs1, q0} : i_buf1;
  // Sign of the remainder against the divisor sets the correction direction
  assign quot_dec = i_buf0[XLEN] ^ s2;

  always_comb begin
    op1        = (i_state == ST_IDLE) ? {DIV_W{s1}} : {sft1_q, i_buf0};
    op2        = divisor;
    o_sub      = (i_state == ST_IDLE) ? q0 : i_buf1[0];
    o_buf0_nxt = {i_sum[XLEN-1:0], q_src[XLEN]};
    o_buf1_nxt = {q_src[XLEN-1:0], cur_q};
    case (i_state)
      ST_EXEC: begin
        // Final step keeps the remainder unshifted and ends the quotient in 1
        if (i_cnt == cnt_t'(DIV_STEPS)) begin
          o_buf0_nxt = i_sum[XLEN:0];
          o_buf1_nxt = {i_buf1[XLEN-1:0], 1'b1};
        end
      end
      ST_REMD_CHCK: begin
        op1   = {i_buf0[XLEN], i_buf0};
        o_sub = 1'b0;
      end
      ST_QUOT_CORR: begin
        op1        = {i_buf1[XLEN], i_buf1};
        op2        = DIV_W'(1);
        o_sub      = quot_dec;
        o_buf1_nxt = i_sum[XLEN:0];
      end
      ST_REMD_CORR: begin
        op1        = {i_buf0[XLEN], i_buf0};
        o_sub      = ~quot_dec;
        o_buf0_nxt = i_sum[XLEN:0];
      end
      default: ;
    endcase
  end

  assign o_op1 = {1'b0, op1};
  assign o_op2 = {1'b0, op2};

  // Adder bit 32 extends the stored remainder on the next step
  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      sft1_q <= 1'b0;
    end else if (i_buf0_ena) begin
      sft1_q <= i_sum[XLEN];
    end
  end

  // Correct when the remainder sign is wrong or it equals +/- divisor
  assign o_need_corr = (i_state == ST_REMD_CHCK) & i_op[2]
                     & ((((i_buf0[XLEN] ^ s1) & (i_buf0 != '0)))
                       | (i_sum[DIV_W-1:0] == '0)
                       | (i_buf0 == divisor[XLEN:0]));

  ////////////////////////////////////////////////////////////
  // Special cases and result

  assign div_by_0 = (i_rs2 == '0);
  assign div_ovf  = ((i_op == OP_DIV) | (i_op == OP_REM)) & (&i_rs2)
                  & (i_rs1 == {1'b1, {(XLEN-1){1'b0}}});
  assign o_special = (i_op[2] & div_by_0) | div_ovf;

  assign special_res = div_by_0 ? (quot_sel ? '1 : i_rs1)
                     : (quot_sel ? {1'b1, {(XLEN-1){1'b0}}} : '0);

  // Corrected remainder is taken from the adder to save a cycle
  assign remd = (i_state == ST_REMD_CORR) ? i_sum[XLEN-1:0] : i_buf0[XLEN-1:0];

  assign o_result = o_special ? special_res
                  : quot_sel  ? i_buf1[XLEN-1:0]
                  :             remd;

  // A special request never starts the steps, and a running divide keeps its operands
  a_special_idle: assert property (@(posedge clk) disable iff (!i_arst_n)
    o_special |-> (i_state == ST_IDLE))
    else $error("special case flagged while an operation is running");

endmodule

`default_nettype wire

//--- src/muldiv_shared_dp.sv
////////////////////////////////////////////////////////////
// Shared adder and the two 33-bit step registers used by
// both the multiplier and the divider, plus result select.
////////////////////////////////////////////////////////////
`default_nettype none

module muldiv_shared_dp (
  input  wire logic                          clk,
  input  wire logic                          i_arst_n,
  input  wire muldiv_ctrl_pkg::muldiv_op_e   i_op,
  input  wire muldiv_data_pkg::sum_t         i_mul_op1,
  input  wire muldiv_data_pkg::sum_t         i_mul_op2,
  input  wire logic                          i_mul_sub,
  input  wire muldiv_data_pkg::sum_t         i_div_op1,
  input  wire muldiv_data_pkg::sum_t         i_div_op2,
  input  wire logic                          i_div_sub,
  input  wire muldiv_data_pkg::ext_t         i_mul_buf0_nxt,
  input  wire muldiv_data_pkg::ext_t         i_mul_buf1_nxt,
  input  wire muldiv_data_pkg::ext_t         i_div_buf0_nxt,
  input  wire muldiv_data_pkg::ext_t         i_div_buf1_nxt,
  input  wire logic                          i_buf0_ena,
  input  wire logic                          i_buf1_ena,
  input  wire muldiv_data_pkg::xlen_t        i_mul_result,
  input  wire muldiv_data_pkg::xlen_t        i_div_result,
  input  wire logic                          i_special,
  output muldiv_data_pkg::sum_t              o_sum,
  output muldiv_data_pkg::ext_t              o_buf0,
  output muldiv_data_pkg::ext_t              o_buf1,
  output muldiv_data_pkg::xlen_t             o_wdata
);
  import muldiv_data_pkg::*;
  import muldiv_ctrl_pkg::*;

  logic is_div;
  sum_t op1;
  sum_t op2;
  logic sub;

  assign is_div = i_op[2];
  assign op1    = is_div ? i_div_op1 : i_mul_op1;
  assign op2    = is_div ? i_div_op2 : i_mul_op2;
  assign sub    = is_div ? i_div_sub : i_mul_sub;

  // Subtract as invert plus carry in
  assign o_sum = op1 + (sub ? ~op2 : op2) + sum_t'(sub);

  // buf0 holds product high or remainder, buf1 product low or quotient
  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_buf0 <= '0;
      o_buf1 <= '0;
    end else begin
      if (i_buf0_ena) o_buf0 <= is_div ? i_div_buf0_nxt : i_mul_buf0_nxt;
      if (i_buf1_ena) o_buf1 <= is_div ? i_div_buf1_nxt : i_mul_buf1_nxt;
    end
  end

  // Special answers come only from the divider path
  assign o_wdata = (is_div | i_special) ? i_div_result : i_mul_result;

endmodule

`default_nettype wire

//--- src/muldiv_top.sv
////////////////////////////////////////////////////////////
// Top of the sequential RISC-V M-extension unit. Request and
// result complete together in one valid/ready handshake.
////////////////////////////////////////////////////////////
`default_nettype none

module muldiv_top (
  input  wire logic                          clk,
  input  wire logic                          i_arst_n,
  input  wire logic                          i_valid,
  input  wire muldiv_ctrl_pkg::muldiv_op_e   i_op,
  input  wire muldiv_data_pkg::xlen_t        i_rs1,
  input  wire muldiv_data_pkg::xlen_t        i_rs2,
  input  wire logic                          i_o_ready,
  output logic                               o_i_ready,
  output logic                               o_valid,
  output muldiv_data_pkg::xlen_t             o_wdata
);
  import muldiv_data_pkg::*;
  import muldiv_ctrl_pkg::*;

  muldiv_state_e state;
  cnt_t          cnt;
  logic          buf0_ena;
  logic          buf1_ena;
  logic          need_corr;
  logic          special;
  sum_t          sum;
  ext_t          buf0;
  ext_t          buf1;
  // Multiplier side
  sum_t          mul_op1;
  sum_t          mul_op2;
  logic          mul_sub;
  ext_t          mul_buf0_nxt;
  ext_t          mul_buf1_nxt;
  xlen_t         mul_result;
  // Divider side
  sum_t          div_op1;
  sum_t          div_op2;
  logic          div_sub;
  ext_t          div_buf0_nxt;
  ext_t          div_buf1_nxt;
  xlen_t         div_result;

  muldiv_fsm u_fsm (
    .clk, .i_arst_n, .i_valid, .i_op,
    .i_special(special), .i_need_corr(need_corr), .i_o_ready,
    .o_i_ready, .o_valid, .o_state(state), .o_cnt(cnt),
    .o_buf0_ena(buf0_ena), .o_buf1_ena(buf1_ena)
  );

  muldiv_booth u_booth (
    .clk, .i_arst_n, .i_rs1, .i_rs2, .i_op, .i_state(state), .i_cnt(cnt),
    .i_buf0(buf0), .i_buf1(buf1), .i_sum(sum), .i_buf1_ena(buf1_ena),
    .o_op1(mul_op1), .o_op2(mul_op2), .o_sub(mul_sub),
    .o_buf0_nxt(mul_buf0_nxt), .o_buf1_nxt(mul_buf1_nxt), .o_result(mul_result)
  );

  muldiv_nrdiv u_nrdiv (
    .clk, .i_arst_n, .i_rs1, .i_rs2, .i_op, .i_state(state), .i_cnt(cnt),
    .i_buf0(buf0), .i_buf1(buf1), .i_sum(sum), .i_buf0_ena(buf0_ena),
    .o_op1(div_op1), .o_op2(div_op2), .o_sub(div_sub),
    .o_buf0_nxt(div_buf0_nxt), .o_buf1_nxt(div_buf1_nxt),
    .o_need_corr(need_corr), .o_special(special), .o_result(div_result)
  );

  muldiv_shared_dp u_dp (
    .clk, .i_arst_n, .i_op,
    .i_mul_op1(mul_op1), .i_mul_op2(mul_op2), .i_mul_sub(mul_sub),
    .i_div_op1(div_op1), .i_div_op2(div_op2), .i_div_sub(div_sub),
    .i_mul_buf0_nxt(mul_buf0_nxt), .i_mul_buf1_nxt(mul_buf1_nxt),
    .i_div_buf0_nxt(div_buf0_nxt), .i_div_buf1_nxt(div_buf1_nxt),
    .i_buf0_ena(buf0_ena), .i_buf1_ena(buf1_ena),
    .i_mul_result(mul_result), .i_div_result(div_result), .i_special(special),
    .o_sum(sum), .o_buf0(buf0), .o_buf1(buf1), .o_wdata
  );

endmodule

`default_nettype wire

//--- tb/muldiv_model.svh
////////////////////////////////////////////////////////////
// Reference model of the RISC-V M operations and the LFSR
// step for the testbench. Included inside the testbench module.
////////////////////////////////////////////////////////////
`ifndef MULDIV_MODEL_SVH
`define MULDIV_MODEL_SVH

// Fibonacci LFSR, taps 16/14/13/11, new bit enters at the bottom
function automatic logic [15:0] lfsr_next(input logic [15:0] s);
  logic fb;
  fb = s[15] ^ s[13] ^ s[12] ^ s[10];
  return {s[14:0], fb};
endfunction

// Expected result word for one request
function automatic xlen_t model_result(input muldiv_op_e op, input xlen_t a, input xlen_t b);
  logic [63:0] pa;
  logic [63:0] pb;
  logic [63:0] prod;
  logic        a_sgn;
  logic        b_sgn;
  logic        div_sgn;
  logic        neg_a;
  logic        neg_b;
  xlen_t       ma;
  xlen_t       mb;
  xlen_t       q;
  xlen_t       r;
  // 64-bit product of the extended operands, modulo 2^64
  a_sgn = (op == OP_MUL) || (op == OP_MULH) || (op == OP_MULHSU);
  b_sgn = (op == OP_MUL) || (op == OP_MULH);
  pa    = {{XLEN{a_sgn & a[XLEN-1]}}, a};
  pb    = {{XLEN{b_sgn & b[XLEN-1]}}, b};
  prod  = pa * pb;
  // Truncating division on magnitudes, signs applied afterwards
  div_sgn = (op == OP_DIV) || (op == OP_REM);
  if (b == '0) begin
    q = '1;
    r = a;
  end else if (div_sgn && (a == 32'h8000_0000) && (b == '1)) begin
    q = a;
    r = '0;
  end else begin
    neg_a = div_sgn & a[XLEN-1];
    neg_b = div_sgn & b[XLEN-1];
    ma    = neg_a ? -a : a;
    mb    = neg_b ? -b : b;
    q     = ma / mb;
    r     = ma % mb;
    if (neg_a ^ neg_b) q = -q;
    // Remainder takes the dividend's sign
    if (neg_a) r = -r;
  end
  case (op)
    OP_MUL:              return prod[XLEN-1:0];
    OP_MULH, OP_MULHSU,
    OP_MULHU:            return prod[2*XLEN-1:XLEN];
    OP_DIV, OP_DIVU:     return q;
    default:             return r;
  endcase
endfunction

`endif

//--- tb/tb_muldiv.sv
////////////////////////////////////////////////////////////
// Testbench of the multiply/divide unit. Random operations
// from an LFSR, checked against the model, with back-pressure.
////////////////////////////////////////////////////////////
`default_nettype none

module tb_muldiv;
  import muldiv_data_pkg::*;
  import muldiv_ctrl_pkg::*;

  `include "muldiv_model.svh"

  localparam int N_DIRECTED = 6;
  localparam int N_RANDOM   = 400;
  // Worst op is 35 steps plus stall, handshake and idle cycle
  localparam int CYCLE_LIMIT = (N_DIRECTED + N_RANDOM) * 40 + 16 + 200;

  logic       clk;
  logic       i_arst_n;
  logic       i_valid;
  muldiv_op_e i_op;
  xlen_t      i_rs1;
  xlen_t      i_rs2;
  logic       i_o_ready;
  logic       o_i_ready;
  logic       o_valid;
  xlen_t      o_wdata;
  logic [15:0] lfsr_q;
  int         cycles;
  int         n_div_plain;
  int         n_div_corr;

  muldiv_top dut (
    .clk, .i_arst_n, .i_valid, .i_op, .i_rs1, .i_rs2, .i_o_ready,
    .o_i_ready, .o_valid, .o_wdata
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////
  // Failure reporting and compare tasks

  task automatic stop_with_failure();
    $display("*** TEST FAILED ***");
    $fatal(1);
  endtask

  task automatic check_wdata(input string name, input xlen_t exp, input xlen_t act);
    if (act !== exp) begin
      $display("ERROR time=%0t %s expected=%h actual=%h", $time, name, exp, act);
      stop_with_failure();
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("ERROR time=%0t %s expected=%b actual=%b", $time, name, exp, act);
      stop_with_failure();
    end
  endtask

  // Hang guard, counts from time zero
  initial begin
    cycles = 0;
    while (cycles < CYCLE_LIMIT) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
    stop_with_failure();
  end

  ////////////////////////////////////////////////////////////
  // Random stimulus

  // One LFSR step per bit taken
  task automatic draw_bits(input int n, output xlen_t v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      v      = {v[XLEN-2:0], lfsr_q[0]};
    end
  endtask

  // Corner values and small numbers come up often
  task automatic pick_operand(output xlen_t v);
    xlen_t cls;
    draw_bits(3, cls);
    case (cls[2:0])
      3'd0:       v = '0;
      3'd1:       v = '1;
      3'd2:       v = 32'h8000_0000;
      3'd3, 3'd4: draw_bits(4, v);
      default:    draw_bits(XLEN, v);
    endcase
  endtask

  // One request from presentation to handshake, plus an idle cycle
  task automatic run_op(input muldiv_op_e op, input xlen_t a, input xlen_t b);
    xlen_t exp;
    xlen_t bits;
    logic  stall;
    int    stall_len;
    int    lat;
    logic  special;
    logic  lat_ok;
    exp = model_result(op, a, b);
    draw_bits(2, bits);
    stall     = bits[1];
    stall_len = bits[0] ? 2 : 1;
    special   = op[2] && ((b == '0) || (((op == OP_DIV) || (op == OP_REM))
                && (a == 32'h8000_0000) && (b == '1)));
    @(posedge clk);
    i_valid   <= 1'b1;
    i_op      <= op;
    i_rs1     <= a;
    i_rs2     <= b;
    i_o_ready <= ~stall;
    lat = 0;
    @(negedge clk);
    while (!o_valid && (lat < 40)) begin
      check_flag("o_i_ready", 1'b0, o_i_ready);
      @(posedge clk);
      lat++;
      @(negedge clk);
    end
    // Latency follows the operation class
    if (special) lat_ok = (lat == 0);
    else if (!op[2]) lat_ok = (lat == MUL_STEPS);
    else lat_ok = (lat == 33) || (lat == 35);
    if (!lat_ok) begin
      $display("Wrong latency: op %0d with rs1=%h rs2=%h answered after %0d cycles",
               op, a, b, lat);
      stop_with_failure();
    end
    // The longer divide latency marks the corrected path
    if (op[2] && !special) begin
      if (lat == 35) n_div_corr++;
      else n_div_plain++;
    end
    check_wdata("o_wdata", exp, o_wdata);
    if (stall) begin
      // Result must hold while the consumer stalls
      check_flag("o_i_ready", 1'b0, o_i_ready);
      for (int k = 1; k < stall_len; k++) begin
        @(posedge clk);
        @(negedge clk);
        check_flag("o_valid", 1'b1, o_valid);
        check_flag("o_i_ready", 1'b0, o_i_ready);
        check_wdata("o_wdata", exp, o_wdata);
      end
      @(posedge clk);
      i_o_ready <= 1'b1;
      @(negedge clk);
      check_flag("o_valid", 1'b1, o_valid);
      check_wdata("o_wdata", exp, o_wdata);
    end
    check_flag("o_i_ready", 1'b1, o_i_ready);
    @(posedge clk);
    i_valid   <= 1'b0;
    i_o_ready <= 1'b0;
    @(negedge clk);
    check_flag("o_valid", 1'b0, o_valid);
    check_flag("o_i_ready", 1'b0, o_i_ready);
  endtask

  initial begin
    xlen_t a;
    xlen_t b;
    xlen_t opbits;
    i_arst_n    = 1'b0;
    i_valid     = 1'b0;
    i_op        = OP_MUL;
    i_rs1       = '0;
    i_rs2       = '0;
    i_o_ready   = 1'b0;
    lfsr_q      = 16'd41574;
    n_div_plain = 0;
    n_div_corr  = 0;
    repeat (16) @(posedge clk);
    i_arst_n <= 1'b1;
    @(negedge clk);
    check_flag("o_valid", 1'b0, o_valid);
    check_flag("o_i_ready", 1'b0, o_i_ready);

    // Divide by zero and signed overflow
    run_op(OP_DIV, 32'h1234_5678, '0);
    run_op(OP_DIVU, 32'hfedc_ba98, '0);
    run_op(OP_REM, 32'h8765_4321, '0);
    run_op(OP_REMU, 32'h0bad_cafe, '0);
    run_op(OP_DIV, 32'h8000_0000, '1);
    run_op(OP_REM, 32'h8000_0000, '1);

    for (int n = 0; n < N_RANDOM; n++) begin
      draw_bits(3, opbits);
      pick_operand(a);
      pick_operand(b);
      run_op(muldiv_op_e'(opbits[2:0]), a, b);
    end

    // Both divide paths must have run
    if ((n_div_plain == 0) || (n_div_corr == 0)) begin
      $display("Divide paths not both run: %0d uncorrected and %0d corrected divides",
               n_div_plain, n_div_corr);
      stop_with_failure();
    end else begin
      $display("*** TEST PASSED ***");
      $finish;
    end
  end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+tb
src/muldiv_data_pkg.sv
src/muldiv_ctrl_pkg.sv
src/muldiv_fsm.sv
src/muldiv_booth.sv
src/muldiv_nrdiv.sv
src/muldiv_shared_dp.sv
src/muldiv_top.sv
tb/tb_muldiv.sv

//--- Bender.yml
package:
  name: muldiv

sources:
  - src/muldiv_data_pkg.sv
  - src/muldiv_ctrl_pkg.sv
  - src/muldiv_fsm.sv
  - src/muldiv_booth.sv
  - src/muldiv_nrdiv.sv
  - src/muldiv_shared_dp.sv
  - src/muldiv_top.sv
  - target: test
    include_dirs:
      - tb
    files:
      - tb/tb_muldiv.sv
